// ==== bus_cycle_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_fsm (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     m2,
	input  wire epsm_pkg::cpu_bus_t cpu,
	output logic                    wr,
	output epsm_pkg::port_write_t   wdata
);

	// ******************************
	// m2 synchronizer
	// ******************************
	logic m2_meta;
	logic m2_sync;

	always_ff @(posedge clk) begin
		if (!rst) begin
			m2_meta <= 1'b0;
			m2_sync <= 1'b0;
		end else begin
			m2_meta <= m2;
			m2_sync <= m2_meta;
		end
	end

	// ******************************
	// bus phase tracking
	// ******************************
	epsm_pkg::bus_state_t state;
	epsm_pkg::cpu_bus_t   cap;    // bus as of the last m2-high clk
	logic                 hit;
	logic                 pend;   // falling edge seen, judged cycle

	// write to $401C..$401F, outside rom space
	assign hit = !cap.rw && cap.romsel_n &&
		cap.addr >= epsm_pkg::port_base &&
		cap.addr <= epsm_pkg::port_base + 15'd3;

	always_ff @(posedge clk) begin
		if (m2_sync) begin
			cap <= cpu; // keep sampling until m2 drops
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= epsm_pkg::m2_low;
			pend  <= 1'b0;
			wr    <= 1'b0;
		end else begin
			pend <= 1'b0;
			wr   <= pend; // one stage after the judgement
			case (state)
				epsm_pkg::m2_low: begin
					if (m2_sync) begin
						state <= epsm_pkg::m2_high;
					end
				end
				epsm_pkg::m2_high: begin
					if (!m2_sync) begin
						state <= epsm_pkg::m2_low;
						pend  <= hit;
					end
				end
				default: state <= epsm_pkg::m2_low;
			endcase
		end
	end

	// cap is frozen while m2 is low, so this holds through wr
	assign wdata.port = cap.addr[1:0];
	assign wdata.data = cap.data;

endmodule

`default_nettype wire

// ==== epsm_irq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module epsm_irq_top #(
	parameter int DIV_A      = 900, // clk cycles per timer A tick
	parameter int DIV_B_MULT = 16   // timer B tick is this many A ticks
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire epsm_pkg::cpu_addr_t cpu_addr,
	input  wire epsm_pkg::cpu_data_t cpu_data,
	input  wire                  cpu_rw,
	input  wire                  cpu_romsel_n,
	input  wire                  m2,
	output logic                 irq_n
);

	// ******************************
	// internal nets
	// ******************************
	epsm_pkg::cpu_bus_t    cpu_bus;
	epsm_pkg::port_write_t wdata;
	logic                  wr;

	epsm_pkg::period_a_t   period_a;
	epsm_pkg::period_b_t   period_b;
	epsm_pkg::timer_ctrl_t ctrl;
	logic [1:0]            clr;   // bit 0 = A, bit 1 = B

	logic                  ovf_a;
	logic                  ovf_b;

	assign cpu_bus = '{
		addr:     cpu_addr,
		data:     cpu_data,
		rw:       cpu_rw,
		romsel_n: cpu_romsel_n
	};

	// ******************************
	// cpu side
	// ******************************
	bus_cycle_fsm bus_fsm0 (
		.clk   (clk),
		.rst   (rst),
		.m2    (m2),
		.cpu   (cpu_bus),
		.wr    (wr),
		.wdata (wdata)
	);

	epsm_regs regs0 (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.wdata    (wdata),
		.period_a (period_a),
		.period_b (period_b),
		.ctrl     (ctrl),
		.clr      (clr)
	);

	// ******************************
	// timers and irq
	// ******************************
	epsm_timer #(.WIDTH(10), .DIV(DIV_A)) timer_a (
		.clk    (clk),
		.rst    (rst),
		.enable (ctrl.enable_a),
		.period (period_a),
		.ovf    (ovf_a)
	);

	epsm_timer #(.WIDTH(8), .DIV(DIV_A * DIV_B_MULT)) timer_b (
		.clk    (clk),
		.rst    (rst),
		.enable (ctrl.enable_b),
		.period (period_b),
		.ovf    (ovf_b)
	);

	irq_flags flags0 (
		.clk   (clk),
		.rst   (rst),
		.ovf_a (ovf_a),
		.ovf_b (ovf_b),
		.ctrl  (ctrl),
		.clr   (clr),
		.irq_n (irq_n)
	);

endmodule

`default_nettype wire

// ==== epsm_pkg.sv ====
`default_nettype none

package epsm_pkg;

	// ******************************
	// bus and register widths
	// ******************************
	typedef logic [14:0] cpu_addr_t; // no A15 on the cart edge
	typedef logic [7:0]  cpu_data_t;
	typedef logic [7:0]  reg_index_t;
	typedef logic [9:0]  period_a_t;
	typedef logic [7:0]  period_b_t;
	typedef logic [1:0]  port_sel_t; // picks one of $401C..$401F

	// cpu pins as seen by the cartridge
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t data;
		logic      rw;       // high = read
		logic      romsel_n; // low for $8000..$FFFF
	} cpu_bus_t;

	// one accepted write to a sound-chip port
	typedef struct packed {
		port_sel_t port;
		cpu_data_t data;
	} port_write_t;

	typedef struct packed {
		logic enable_a;
		logic enable_b;
		logic permit_a;
		logic permit_b;
		logic unmask_a;
		logic unmask_b;
	} timer_ctrl_t;

	typedef enum logic {m2_low, m2_high} bus_state_t;

	localparam cpu_addr_t port_base = 15'h401C;

	// sound-chip register indices
	localparam reg_index_t idx_period_a_hi = 8'h24;
	localparam reg_index_t idx_period_a_lo = 8'h25;
	localparam reg_index_t idx_period_b    = 8'h26;
	localparam reg_index_t idx_control     = 8'h27;
	localparam reg_index_t idx_unmask      = 8'h29;

endpackage

`default_nettype wire

// ==== epsm_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module epsm_regs (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        wr,
	input  wire epsm_pkg::port_write_t wdata,
	output epsm_pkg::period_a_t        period_a,
	output epsm_pkg::period_b_t        period_b,
	output epsm_pkg::timer_ctrl_t      ctrl,
	output logic [1:0]                 clr
);

	epsm_pkg::reg_index_t index;
	logic                 data_wr;  // ports 1 and 3
	logic                 index_wr; // ports 0 and 2

	assign data_wr  = wr && wdata.port[0];
	assign index_wr = wr && !wdata.port[0];

	// ******************************
	// index latch
	// ******************************
	always_ff @(posedge clk) begin
		if (!rst) begin
			index <= '0;
		end else if (index_wr) begin
			index <= wdata.data;
		end
	end

	// ******************************
	// register file
	// ******************************
	always_ff @(posedge clk) begin
		if (!rst) begin
			period_a <= '0;
			period_b <= '0;
			ctrl     <= '0;
		end else if (data_wr) begin
			case (index)
				epsm_pkg::idx_period_a_hi: begin
					period_a[9:2] <= wdata.data;
				end
				epsm_pkg::idx_period_a_lo: begin
					period_a[1:0] <= wdata.data[1:0]; // upper bits unused
				end
				epsm_pkg::idx_period_b: begin
					period_b <= wdata.data;
				end
				epsm_pkg::idx_control: begin
					ctrl.enable_a <= wdata.data[0];
					ctrl.enable_b <= wdata.data[1];
					ctrl.permit_a <= wdata.data[2];
					ctrl.permit_b <= wdata.data[3];
				end
				epsm_pkg::idx_unmask: begin
					ctrl.unmask_a <= wdata.data[0];
					ctrl.unmask_b <= wdata.data[1];
				end
				default: begin
					// other chip registers are not ours
				end
			endcase
		end
	end

	// flag reset requests, valid only during the wr cycle
	always_comb begin
		clr = 2'b00;
		if (data_wr && index == epsm_pkg::idx_control) begin
			clr = wdata.data[5:4];
		end
	end

endmodule

`default_nettype wire

// ==== epsm_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module epsm_timer #(
	parameter int WIDTH = 10,
	parameter int DIV   = 900
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              enable,
	input  wire [WIDTH-1:0]  period,
	output logic             ovf
);

	localparam int PW = (DIV > 1) ? $clog2(DIV) : 1;

	// ******************************
	// prescaler
	// ******************************
	logic [PW-1:0] pre;
	logic          tick;

	assign tick = (pre == PW'(DIV - 1));

	always_ff @(posedge clk) begin
		if (!rst) begin
			pre <= '0;
		end else if (tick) begin
			pre <= '0;
		end else begin
			pre <= pre + 1'b1; // free running, even when disabled
		end
	end

	// ******************************
	// reloading up-counter
	// ******************************
	logic [WIDTH-1:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst) begin
			cnt <= '0;
			ovf <= 1'b0;
		end else begin
			ovf <= 1'b0;
			if (!enable) begin
				cnt <= '0;
			end else if (tick) begin
				if (cnt == '0) begin
					cnt <= period; // reload
				end else if (cnt == {WIDTH{1'b1}}) begin
					cnt <= '0;
					ovf <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== irq_flags.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_flags (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        ovf_a,
	input  wire                        ovf_b,
	input  wire epsm_pkg::timer_ctrl_t ctrl,
	input  wire [1:0]                  clr,
	output logic                       irq_n
);

	logic flag_a;
	logic flag_b;
	logic set_a;
	logic set_b;

	// overflow only counts when permitted
	assign set_a = ovf_a && ctrl.permit_a;
	assign set_b = ovf_b && ctrl.permit_b;

	// ******************************
	// sticky flags
	// ******************************
	always_ff @(posedge clk) begin
		if (!rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			flag_a <= set_a || (flag_a && !clr[0]); // set beats clear
			flag_b <= set_b || (flag_b && !clr[1]);
		end
	end

	// open-drain style, low while any unmasked flag is up
	assign irq_n = !((flag_a && ctrl.unmask_a) || (flag_b && ctrl.unmask_b));

endmodule

`default_nettype wire

// ==== project.f ====
epsm_pkg.sv
bus_cycle_fsm.sv
epsm_regs.sv
epsm_timer.sv
irq_flags.sv
epsm_irq_top.sv
tb_clock_gen.sv
tb_epsm_irq.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it into sim.log and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module tb_epsm_irq -o tb_epsm_irq \
	&& ./obj_dir/tb_epsm_irq > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD = 4.0 // ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2.0) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// ==== tb_epsm_irq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_epsm_irq;

	// ******************************
	// run lengths in clk cycles
	// ******************************
	localparam int DIV_A      = 8;
	localparam int DIV_B_MULT = 16;
	localparam int DIV_B      = DIV_A * DIV_B_MULT;
	localparam int BUS_CYCLE  = 12;  // m2 high 6, low 6
	localparam int PA_MIN     = 944; // random periods stay in a short range
	localparam int PB_MIN     = 246;
	localparam int A_SPAN_MAX = (1023 - PA_MIN + 2) * DIV_A;
	localparam int B_SPAN_MAX = (255 - PB_MIN + 2) * DIV_B;
	localparam int IDLE_HOLD  = B_SPAN_MAX + 2 * DIV_B; // longer than any enabled interval
	localparam int WATCHDOG_CYCLES = 4 + 40 * BUS_CYCLE + IDLE_HOLD +
		2 * (A_SPAN_MAX + 32) + 5 * (B_SPAN_MAX + DIV_B) + 1000;

	logic                clk;
	logic                rst;
	epsm_pkg::cpu_addr_t cpu_addr;
	epsm_pkg::cpu_data_t cpu_data;
	logic                cpu_rw;
	logic                cpu_romsel_n;
	logic                m2;
	logic                irq_n;

	logic        want_high; // irq_n must be high at every edge
	logic        want_low;
	int          high_errors;
	int          low_errors;
	logic [31:0] lfsr_state;

	tb_clock_gen #(.PERIOD(4.0)) clk_gen0 (.clk(clk));

	epsm_irq_top #(.DIV_A(DIV_A), .DIV_B_MULT(DIV_B_MULT)) dut0 (
		.clk          (clk),
		.rst          (rst),
		.cpu_addr     (cpu_addr),
		.cpu_data     (cpu_data),
		.cpu_rw       (cpu_rw),
		.cpu_romsel_n (cpu_romsel_n),
		.m2           (m2),
		.irq_n        (irq_n)
	);

	// ******************************
	// irq_n checks
	// ******************************
	high_check: assert property (@(posedge clk) disable iff (!rst) (!want_high || irq_n))
		else begin
			high_errors++;
			$display("Fail at %0t: irq_n expected 1, actual %0b", $time, $sampled(irq_n));
		end

	low_check: assert property (@(posedge clk) disable iff (!rst) (!want_low || !irq_n))
		else begin
			low_errors++;
			$display("Fail at %0t: irq_n expected 0, actual %0b", $time, $sampled(irq_n));
		end

	// galois form, right shift
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]}; // one step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// every wait ends 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic bus_cycle(input epsm_pkg::cpu_addr_t addr, input epsm_pkg::cpu_data_t data,
			input logic rw, input logic romsel_n);
		cpu_addr     = addr;
		cpu_data     = data;
		cpu_rw       = rw;
		cpu_romsel_n = romsel_n;
		m2           = 1'b1;
		wait_cycles(6);
		m2 = 1'b0; // bus held, the FSM captures until m2_sync drops
		wait_cycles(6);
	endtask

	task automatic write_port(input epsm_pkg::port_sel_t port, input epsm_pkg::cpu_data_t data);
		bus_cycle(epsm_pkg::port_base + 15'(port), data, 1'b0, 1'b1);
	endtask

	// upper picks the $401E/$401F pair
	task automatic write_reg(input epsm_pkg::reg_index_t idx, input epsm_pkg::cpu_data_t data,
			input logic upper);
		write_port({upper, 1'b0}, idx);
		write_port({upper, 1'b1}, data);
	endtask

	task automatic hold_high(input int n);
		want_high = 1'b1;
		wait_cycles(n);
		want_high = 1'b0;
	endtask

	task automatic hold_low(input int n);
		want_low = 1'b1;
		wait_cycles(n);
		want_low = 1'b0;
	endtask

	task automatic expect_low_within(input int limit);
		int   i;
		logic seen;
		seen = 1'b0;
		i = 0;
		while (!seen && i < limit) begin
			wait_cycles(1);
			seen = !irq_n;
			i++;
		end
		if (!seen) begin
			want_low = 1'b1; // low check fires on the next edge
			wait_cycles(1);
			want_low = 1'b0;
		end
	endtask

	// ******************************
	// stimulus
	// ******************************
	initial begin
		logic [31:0] r;
		int          p_a;
		int          p_b;
		int          span;
		rst          = 1'b0;
		m2           = 1'b0;
		cpu_addr     = '0;
		cpu_data     = '0;
		cpu_rw       = 1'b1;
		cpu_romsel_n = 1'b1;
		want_high    = 1'b0;
		want_low     = 1'b0;
		high_errors  = 0;
		low_errors   = 0;
		lfsr_state   = 32'h77629d6a;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b1;

		$display("test 1: timers disabled");
		want_high = 1'b1;
		take_bits(6, r);
		p_a = 1007 - int'(r[5:0]);
		write_reg(epsm_pkg::idx_period_a_hi, 8'(p_a >> 2), 1'b0);
		write_reg(epsm_pkg::idx_period_a_lo, 8'(p_a & 3), 1'b1);
		take_bits(3, r);
		p_b = 253 - int'(r[2:0]);
		write_reg(epsm_pkg::idx_period_b, 8'(p_b), 1'b0);
		write_reg(epsm_pkg::idx_unmask, 8'h03, 1'b1);
		write_reg(epsm_pkg::idx_control, 8'h0C, 1'b0); // permits only
		wait_cycles(IDLE_HOLD);
		want_high = 1'b0;

		$display("test 2: timer A overflow");
		take_bits(6, r);
		p_a = 1007 - int'(r[5:0]);
		write_reg(epsm_pkg::idx_unmask, 8'h01, 1'b0);
		write_reg(epsm_pkg::idx_period_a_hi, 8'(p_a >> 2), 1'b0);
		write_reg(epsm_pkg::idx_period_a_lo, 8'(p_a & 3), 1'b1);
		write_reg(epsm_pkg::idx_control, 8'h05, 1'b0);
		hold_high((1024 - p_a) * DIV_A);
		expect_low_within(3 * DIV_A); // first tick lands anywhere in one prescale

		$display("test 3: flag clear with A running");
		// issued right after the flag rose, so the next overflow is a full period away
		write_port(2'd1, 8'h15);
		hold_high((1025 - p_a) * DIV_A - (BUS_CYCLE + 1));
		expect_low_within(2 * DIV_A);

		$display("test 4: timer B overflow and unmask");
		take_bits(3, r);
		p_b = 253 - int'(r[2:0]);
		write_reg(epsm_pkg::idx_unmask, 8'h02, 1'b1);
		write_reg(epsm_pkg::idx_period_b, 8'(p_b), 1'b1);
		write_reg(epsm_pkg::idx_control, 8'h1A, 1'b0); // B on, permit B, clear A
		hold_high((256 - p_b) * DIV_B);
		expect_low_within(DIV_B + 2 * DIV_A);
		write_reg(epsm_pkg::idx_unmask, 8'h00, 1'b0);
		hold_high(20);
		write_reg(epsm_pkg::idx_unmask, 8'h02, 1'b0);
		hold_low(20); // flag still up from the last overflow

		$display("test 5: B without permit, rejected bus cycles");
		span = (257 - p_b) * DIV_B;
		write_reg(epsm_pkg::idx_control, 8'h22, 1'b0); // B on, clear B
		want_high = 1'b1;
		wait_cycles(2 * span + 16);
		bus_cycle(epsm_pkg::port_base, epsm_pkg::idx_control, 1'b1, 1'b1); // reads
		bus_cycle(epsm_pkg::port_base + 15'd1, 8'h0A, 1'b1, 1'b1);
		bus_cycle(epsm_pkg::port_base, epsm_pkg::idx_control, 1'b0, 1'b0); // rom space
		bus_cycle(epsm_pkg::port_base + 15'd1, 8'h0A, 1'b0, 1'b0);
		wait_cycles(2 * span + 16);
		want_high = 1'b0;

		$display("summary: %0d irq_n high check failures, %0d irq_n low check failures",
			high_errors, low_errors);
		if (high_errors + low_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// ******************************
	// watchdog
	// ******************************
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run still going after %0d clk cycles (%0d high, %0d low failures)",
			WATCHDOG_CYCLES, high_errors, low_errors);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
